/* heapMemory.f */
+incdir+.
heapPkg.sv
heapDirectory.sv
elementStore.sv
elementAlu.sv
heapControl.sv
heapMemory.sv
heapMemoryTb.sv

/* Bender.yml */
package:
  name: heapMemory

sources:
  - heapPkg.sv
  - heapDirectory.sv
  - elementStore.sv
  - elementAlu.sv
  - heapControl.sv
  - heapMemory.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - heapMemoryTb.sv

/* heapMemoryTbTable.svh */
// Heap testbench request table
// Expected results follow the heap rules for allocation, bounds, push, pop and element ops
// Columns: opcode, array, index, input word, err, error kind, dat
task automatic loadTable();
  addRow(opAlloc,    0, 0, 16'h0000, 0, errNone,         16'h0000); // Fresh numbers in order
  addRow(opAlloc,    0, 0, 16'h0000, 0, errNone,         16'h0001);
  addRow(opAlloc,    0, 0, 16'h0000, 0, errNone,         16'h0002);
  addRow(opWrite,    0, 0, 16'h1111, 0, errNone,         16'h0000);
  addRow(opWrite,    0, 1, 16'h2222, 0, errNone,         16'h0000);
  addRow(opWrite,    0, 2, 16'h3333, 0, errNone,         16'h0000);
  addRow(opSize,     0, 0, 16'h0000, 0, errNone,         16'h0003); // Grown to three
  addRow(opWrite,    0, 5, 16'h5555, 0, errNone,         16'h0000); // Past the end
  addRow(opSize,     0, 0, 16'h0000, 0, errNone,         16'h0006);
  addRow(opRead,     0, 1, 16'h0000, 0, errNone,         16'h2222);
  addRow(opRead,     0, 6, 16'h0000, 1, errOutOfBounds,  16'h0000); // At the size
  addRow(opSize,     0, 0, 16'h0000, 0, errNone,         16'h0006); // Unchanged
  addRow(opPop,      1, 0, 16'h0000, 1, errEmpty,        16'h0000);
  addRow(opPush,     1, 0, 16'h000A, 0, errNone,         16'h0000);
  addRow(opPush,     1, 0, 16'h000B, 0, errNone,         16'h0000);
  addRow(opSize,     1, 0, 16'h0000, 0, errNone,         16'h0002);
  addRow(opPop,      1, 0, 16'h0000, 0, errNone,         16'h000B); // Last in first out
  addRow(opPop,      1, 0, 16'h0000, 0, errNone,         16'h000A);
  addRow(opSize,     1, 0, 16'h0000, 0, errNone,         16'h0000);
  addRow(opWrite,    2, 7, 16'h0777, 0, errNone,         16'h0000); // Fills array 2
  addRow(opPush,     2, 0, 16'h1234, 1, errFull,         16'h0000);
  addRow(opAdd,      0, 0, 16'h0001, 0, errNone,         16'h1112); // New value back
  addRow(opAddAfter, 0, 1, 16'h0010, 0, errNone,         16'h2222); // Old value back
  addRow(opRead,     0, 1, 16'h0000, 0, errNone,         16'h2232);
  addRow(opSubAfter, 0, 2, 16'h3334, 0, errNone,         16'h3333); // Leaves 16'hFFFF
  addRow(opAdd,      0, 2, 16'h0002, 0, errNone,         16'h0001); // Wraps
  addRow(opRead,     0, 2, 16'h0000, 0, errNone,         16'h0001);
  addRow(opSub,      0, 0, 16'h0002, 0, errNone,         16'h1110);
  addRow(opOr,       0, 5, 16'h00F0, 0, errNone,         16'h55F5);
  addRow(opXor,      0, 5, 16'hFFFF, 0, errNone,         16'hAA0A);
  addRow(opAnd,      0, 5, 16'h0F0F, 0, errNone,         16'h0A0A);
  addRow(opNot,      0, 5, 16'h0000, 0, errNone,         16'hF5F5); // Operand ignored
  addRow(opFree,     1, 0, 16'h0000, 0, errNone,         16'h0000);
  addRow(opFree,     2, 0, 16'h0000, 0, errNone,         16'h0000);
  addRow(opFree,     2, 0, 16'h0000, 1, errNotAllocated, 16'h0000); // Double free
  addRow(opRead,     1, 0, 16'h0000, 1, errNotAllocated, 16'h0000);
  addRow(opSize,     3, 0, 16'h0000, 1, errNotAllocated, 16'h0000); // Never allocated
  addRow(opAlloc,    0, 0, 16'h0000, 0, errNone,         16'h0002); // Last freed first
  addRow(opAlloc,    0, 0, 16'h0000, 0, errNone,         16'h0001);
  addRow(opSize,     2, 0, 16'h0000, 0, errNone,         16'h0000); // Reused array empty
  addRow(opAlloc,    0, 0, 16'h0000, 0, errNone,         16'h0003); // Back to fresh numbers
  addRow(opAlloc,    0, 0, 16'h0000, 0, errNone,         16'h0004);
  addRow(opAlloc,    0, 0, 16'h0000, 0, errNone,         16'h0005);
  addRow(opAlloc,    0, 0, 16'h0000, 0, errNone,         16'h0006);
  addRow(opAlloc,    0, 0, 16'h0000, 0, errNone,         16'h0007);
  addRow(opAlloc,    0, 0, 16'h0000, 1, errOutOfMemory,  16'h0000); // All eight in use
endtask

/* heapMemoryTb.sv */
// Heap memory testbench
// Request table, random fill with read back, then a mid-run reset
module heapMemoryTb;
  import heapPkg::*;

  typedef struct packed {
    heapOp                op;
    logic [arrayBits-1:0] array;
    logic [indexBits-1:0] index;
    logic [dataBits-1:0]  data;                        // Input word
    logic                 err;                         // Expected err flag
    heapError             kind;
    logic [dataBits-1:0]  dat;                         // Expected result
  } tableRow;

  logic                clock;
  logic                reset;
  wbRequest            request;
  wbResponse           response;
  heapError            errorKind;
  tableRow             rows [$];
  logic [dataBits-1:0] fillWords [arrayLength];        // Copy of the random fill
  logic                gotAck;
  logic                gotErr;
  logic [dataBits-1:0] gotDat;
  integer              seed = 40;
  int                  checkCount = 0;
  int                  errorCount = 0;
  int                  cycleCount = 0;
  int                  cycleLimit = 50;

  heapMemory dut0 (.clock, .reset, .request, .response, .errorKind);

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic addRow(input heapOp op, input int array, input int index,
                        input logic [dataBits-1:0] data, input logic err,
                        input heapError kind, input logic [dataBits-1:0] dat);
    rows.push_back({op, arrayBits'(array), indexBits'(index), data, err, kind, dat});
  endtask

  `include "heapMemoryTbTable.svh"

  task automatic checkValue(input string what, input logic [31:0] seen,
                            input logic [31:0] expected);
    checkCount++;
    if (seen !== expected) begin
      errorCount++;
      $display("Fail at time %0t: %s is %h, expected %h", $time, what, seen, expected);
    end
  endtask

  // One Wishbone classic cycle, called 1 unit after a rising edge
  task automatic runRequest(input heapOp op, input int array, input int index,
                            input logic [dataBits-1:0] data, output logic ack,
                            output logic err, output logic [dataBits-1:0] dat);
    request.cyc       = 1'b1;
    request.stb       = 1'b1;
    request.we        = op inside {opWrite, opPush};    // Informational only
    request.adr.array = arrayBits'(array);
    request.adr.index = indexBits'(index);
    request.dat       = data;
    request.tgc       = op;                             // Opcode on the cycle tag
    do begin
      @(posedge clock);
      #1;
    end while (!(response.ack || response.err));        // Wait for ack or err
    ack     = response.ack;
    err     = response.err;
    dat     = response.dat;
    request = '0;                                       // Drop cyc and stb
    @(posedge clock);
    #1;
    checkValue("ack or err after one cycle", response.ack || response.err, 1'b0);
  endtask

  // ------------------------------
  // Sequence
  // ------------------------------
  initial begin
    request = '0;
    reset   = 1'b1;
    loadTable();
    cycleLimit = 6 * (rows.size() + 2 * arrayLength + 3) + 50;
    repeat (3) @(posedge clock);
    #1 reset = 1'b0;
    foreach (rows[i]) begin
      runRequest(rows[i].op, rows[i].array, rows[i].index, rows[i].data,
                 gotAck, gotErr, gotDat);
      checkValue($sformatf("row %0d ack", i), gotAck, !rows[i].err);
      checkValue($sformatf("row %0d err", i), gotErr, rows[i].err);
      checkValue($sformatf("row %0d errorKind", i), errorKind, rows[i].kind);
      checkValue($sformatf("row %0d dat", i), gotDat, rows[i].dat);
    end
    for (int i = 0; i < arrayLength; i++) begin       // Random fill of array 3
      fillWords[i] = dataBits'($random(seed));
      runRequest(opWrite, 3, i, fillWords[i], gotAck, gotErr, gotDat);
      checkValue($sformatf("fill write %0d err", i), gotErr, 1'b0);
    end
    for (int i = 0; i < arrayLength; i++) begin
      runRequest(opRead, 3, i, 16'h0000, gotAck, gotErr, gotDat);
      checkValue($sformatf("fill read %0d", i), gotDat, fillWords[i]);
    end
    runRequest(opAlloc, 0, 0, 16'h0000, gotAck, gotErr, gotDat); // Every array in use
    checkValue("alloc when full err", gotErr, 1'b1);
    checkValue("errorKind before reset", errorKind, errOutOfMemory);
    reset = 1'b1;                                       // Mid-run reset
    repeat (3) @(posedge clock);
    #1 reset = 1'b0;
    checkValue("errorKind after reset", errorKind, errNone);
    runRequest(opAlloc, 0, 0, 16'h0000, gotAck, gotErr, gotDat);
    checkValue("alloc after reset err", gotErr, 1'b0);
    checkValue("alloc after reset", gotDat, 16'h0000);
    runRequest(opSize, 0, 0, 16'h0000, gotAck, gotErr, gotDat);
    checkValue("size after reset", gotDat, 16'h0000);
    $display("%0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    while (cycleCount < cycleLimit) begin
      @(posedge clock);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
    $display("Verification failed");
    $finish;
  end

endmodule

/* heapMemory.sv */
// Heap memory top level
// Eight arrays of eight words behind a Wishbone classic slave port
module heapMemory (
  input  logic               clock,
  input  logic               reset,
  input  heapPkg::wbRequest  request,
  output heapPkg::wbResponse response,
  output heapPkg::heapError  errorKind
);
  import heapPkg::*;

  directoryCommand     command;
  directoryStatus      status;
  elementAddress       storeReadAddress;
  elementAddress       storeWriteAddress;
  logic [dataBits-1:0] storeReadData;
  logic [dataBits-1:0] storeWriteData;
  logic                storeWriteEnable;
  heapOp               aluOp;
  logic [dataBits-1:0] aluStored;
  logic [dataBits-1:0] aluOperand;
  logic [dataBits-1:0] aluStoreValue;
  logic [dataBits-1:0] aluReturnValue;

  heapControl control0 (
    .clock, .reset, .request, .response, .errorKind,
    .command, .status,
    .storeReadAddress, .storeReadData, .storeWriteEnable,
    .storeWriteAddress, .storeWriteData,
    .aluOp, .aluStored, .aluOperand, .aluStoreValue, .aluReturnValue
  );

  heapDirectory directory0 (.clock, .reset, .command, .status);

  elementStore store0 (
    .clock,
    .readAddress  (storeReadAddress),
    .readData     (storeReadData),
    .writeEnable  (storeWriteEnable),
    .writeAddress (storeWriteAddress),
    .writeData    (storeWriteData)
  );

  elementAlu alu0 (
    .op          (aluOp),
    .stored      (aluStored),
    .operand     (aluOperand),
    .storeValue  (aluStoreValue),
    .returnValue (aluReturnValue)
  );

endmodule

/* heapControl.sv */
// Heap control
// Wishbone classic slave FSM, makes every check and sequences the datapath
module heapControl (
  input  logic                         clock,
  input  logic                         reset,
  input  heapPkg::wbRequest            request,
  output heapPkg::wbResponse           response,
  output heapPkg::heapError            errorKind,
  output heapPkg::directoryCommand     command,
  input  heapPkg::directoryStatus      status,
  output heapPkg::elementAddress       storeReadAddress,
  input  logic [heapPkg::dataBits-1:0] storeReadData,
  output logic                         storeWriteEnable,
  output heapPkg::elementAddress       storeWriteAddress,
  output logic [heapPkg::dataBits-1:0] storeWriteData,
  output heapPkg::heapOp               aluOp,
  output logic [heapPkg::dataBits-1:0] aluStored,
  output logic [heapPkg::dataBits-1:0] aluOperand,
  input  logic [heapPkg::dataBits-1:0] aluStoreValue,
  input  logic [heapPkg::dataBits-1:0] aluReturnValue
);
  import heapPkg::*;

  controlState         state;
  elementAddress       heldAddress;                   // Latched request
  logic [dataBits-1:0] heldData;
  heapOp               heldOp;
  logic [sizeBits-1:0] heldIndex;                     // Index at size width
  logic                elementOp;                     // Needs index inside the size
  logic                modifies;                      // Writes the store
  heapError            fault;                         // Outcome of the checks
  logic                commit;                        // Execute with no fault
  logic [dataBits-1:0] result;

  assign heldIndex = sizeBits'(heldAddress.index);
  assign elementOp = heldOp inside {opRead, opAdd, opAddAfter, opSub, opSubAfter,
                                    opOr, opXor, opAnd, opNot};
  assign modifies  = heldOp inside {opWrite, opPush, opAdd, opAddAfter, opSub,
                                    opSubAfter, opOr, opXor, opAnd, opNot};

  // ------------------------------
  // Checks
  // ------------------------------
  always_comb begin
    fault = errNone;
    if (heldOp == opAlloc) begin
      if (!status.canAllocate) fault = errOutOfMemory;
    end else if (!status.allocated) begin
      fault = errNotAllocated;                        // Also catches a double free
    end else if (elementOp && heldIndex >= status.size) begin
      fault = errOutOfBounds;
    end else if (heldOp == opPush && status.size == sizeBits'(arrayLength)) begin
      fault = errFull;
    end else if (heldOp == opPop && status.size == '0) begin
      fault = errEmpty;
    end
  end

  assign commit = state == stExecute && fault == errNone;

  // ------------------------------
  // Datapath steering
  // ------------------------------
  always_comb begin
    storeReadAddress = heldAddress;
    case (heldOp)
      opPop:   storeReadAddress.index = indexBits'(status.size - 1'b1); // Top element
      opPush:  storeReadAddress.index = status.size[indexBits-1:0];      // First free slot
      default: ;
    endcase
  end

  assign storeWriteAddress = storeReadAddress;        // Write back to the slot read
  assign storeWriteEnable  = commit && modifies;
  assign storeWriteData    = aluStoreValue;
  assign aluOp             = heldOp;
  assign aluStored         = storeReadData;
  assign aluOperand        = heldData;

  always_comb begin
    command            = '0;
    command.array      = heldAddress.array;           // Status follows the request
    command.allocate   = commit && heldOp == opAlloc;
    command.deallocate = commit && heldOp == opFree;
    case (heldOp)
      opWrite: begin                                  // Grow when at or past the end
        command.sizeWrite = commit && heldIndex >= status.size;
        command.newSize   = heldIndex + 1'b1;
      end
      opPush: begin
        command.sizeWrite = commit;
        command.newSize   = status.size + 1'b1;
      end
      opPop: begin
        command.sizeWrite = commit;
        command.newSize   = status.size - 1'b1;
      end
      default: ;
    endcase
  end

  always_comb begin
    case (heldOp)
      opAlloc:                 result = dataBits'(status.allocatedArray);
      opSize:                  result = dataBits'(status.size);
      opWrite, opPush, opFree: result = '0;           // No result
      default:                 result = aluReturnValue;
    endcase
  end

  // ------------------------------
  // FSM and response
  // ------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      state     <= stIdle;
      response  <= '0;
      errorKind <= errNone;
    end else begin
      case (state)
        stIdle:   if (request.cyc && request.stb) state <= stLookup;
        stLookup: state <= stExecute;                 // Store read captured here
        stExecute: begin
          state        <= stRespond;
          response.ack <= fault == errNone;
          response.err <= fault != errNone;
          response.dat <= (fault == errNone) ? result : '0;
          errorKind    <= fault;
        end
        default: begin                                // stRespond ends the cycle
          state    <= stIdle;
          response <= '0;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == stIdle) begin                        // Master holds fields until ack
      heldAddress <= request.adr;
      heldData    <= request.dat;
      heldOp      <= request.tgc;
    end
  end

  ackErrExclusive: assert property (@(posedge clock) disable iff (reset)
    !(response.ack && response.err));

  writeOnlyInExecute: assert property (@(posedge clock) disable iff (reset)
    storeWriteEnable |-> state == stExecute);

endmodule

/* elementAlu.sv */
// Element ALU
// New value to store and value to return for one element operation
module elementAlu (
  input  heapPkg::heapOp               op,
  input  logic [heapPkg::dataBits-1:0] stored,
  input  logic [heapPkg::dataBits-1:0] operand,
  output logic [heapPkg::dataBits-1:0] storeValue,
  output logic [heapPkg::dataBits-1:0] returnValue
);
  import heapPkg::*;

  // ------------------------------
  // Value to store back
  // ------------------------------
  always_comb begin
    case (op)
      opWrite, opPush:   storeValue = operand;        // Plain store
      opAdd, opAddAfter: storeValue = stored + operand; // Wraps at 16 bits
      opSub, opSubAfter: storeValue = stored - operand;
      opOr:              storeValue = stored | operand;
      opXor:             storeValue = stored ^ operand;
      opAnd:             storeValue = stored & operand;
      opNot:             storeValue = ~stored;
      default:           storeValue = stored;         // Read, pop, others unchanged
    endcase
  end

  // ------------------------------
  // Value for the master
  // ------------------------------
  always_comb begin
    case (op)
      opAddAfter, opSubAfter: returnValue = stored;   // Previous value forms
      opRead, opPop:          returnValue = stored;
      default:                returnValue = storeValue; // New value forms
    endcase
  end

endmodule

/* elementStore.sv */
// Element store
// Registered-read word memory for every element of every array
module elementStore (
  input  logic                         clock,
  input  heapPkg::elementAddress       readAddress,
  output logic [heapPkg::dataBits-1:0] readData,
  input  logic                         writeEnable,
  input  heapPkg::elementAddress       writeAddress,
  input  logic [heapPkg::dataBits-1:0] writeData
);
  import heapPkg::*;

  logic [dataBits-1:0] words [elementCount];          // Array number is the upper address

  always_ff @(posedge clock) begin
    if (writeEnable) begin
      words[writeAddress] <= writeData;               // Write lands on the edge
    end
    readData <= words[readAddress];                   // One cycle read latency
  end

endmodule

/* heapDirectory.sv */
// Heap directory
// Tracks per-array size and allocation, reuses freed arrays last in first out
module heapDirectory (
  input  logic                     clock,
  input  logic                     reset,
  input  heapPkg::directoryCommand command,
  output heapPkg::directoryStatus  status
);
  import heapPkg::*;

  logic [sizeBits-1:0]   sizes [arrayCount];          // Size of each array
  logic [arrayCount-1:0] allocatedFlags;              // One flag per array
  logic [arrayBits-1:0]  freedStack [arrayCount];     // Freed array numbers
  logic [sizeBits-1:0]   stackTop;                    // Entries on the freed stack
  logic [sizeBits-1:0]   freshCount;                  // Arrays never handed out
  logic                  stackEmpty;

  assign stackEmpty = stackTop == '0;

  // ------------------------------
  // Status for the commanded array
  // ------------------------------
  always_comb begin
    status.allocated   = allocatedFlags[command.array];
    status.size        = sizes[command.array];
    status.canAllocate = !stackEmpty || freshCount < sizeBits'(arrayCount);
    if (stackEmpty) begin
      status.allocatedArray = freshCount[arrayBits-1:0];  // Next fresh number
    end else begin
      status.allocatedArray = freedStack[arrayBits'(stackTop - 1'b1)]; // Most recent free
    end
  end

  // ------------------------------
  // Updates
  // ------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      allocatedFlags <= '0;                           // Directory empty
      stackTop       <= '0;
      freshCount     <= '0;
      for (int i = 0; i < arrayCount; i++) begin
        sizes[i] <= '0;
      end
    end else begin
      if (command.allocate) begin
        allocatedFlags[status.allocatedArray] <= 1'b1;
        sizes[status.allocatedArray]          <= '0;  // New array starts empty
        if (stackEmpty) begin
          freshCount <= freshCount + 1'b1;
        end else begin
          stackTop <= stackTop - 1'b1;                // Pop the freed stack
        end
      end
      if (command.deallocate) begin
        allocatedFlags[command.array] <= 1'b0;
        stackTop                      <= stackTop + 1'b1;
      end
      if (command.sizeWrite) begin
        sizes[command.array] <= command.newSize;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (command.deallocate) begin
      freedStack[arrayBits'(stackTop)] <= command.array; // Push freed number
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  noReleaseWhenFull: assert property (@(posedge clock) disable iff (reset)
    command.deallocate |-> stackTop < sizeBits'(arrayCount));

  noAllocateWhenExhausted: assert property (@(posedge clock) disable iff (reset)
    command.allocate |-> status.canAllocate);

endmodule

/* heapPkg.sv */
// Heap memory definitions
// Dimensions, opcodes, error kinds and the Wishbone and directory records
package heapPkg;

  // ------------------------------
  // Dimensions
  // ------------------------------
  localparam int arrayBits    = 3;                    // Width of an array number
  localparam int indexBits    = 3;                    // Width of an element index
  localparam int dataBits     = 16;                   // Width of an element
  localparam int arrayCount   = 8;                    // Arrays in the heap
  localparam int arrayLength  = 8;                    // Elements per array
  localparam int sizeBits     = indexBits + 1;        // Size runs 0 to arrayLength
  localparam int elementCount = arrayCount * arrayLength; // Words in the store

  // ------------------------------
  // Opcodes, errors, states
  // ------------------------------
  typedef enum logic [4:0] {
    opAlloc,                                          // Allocate an array
    opFree,                                           // Free an array for reuse
    opWrite,                                          // Write, grows the size
    opRead,                                           // Read an element
    opSize,                                           // Size of an array
    opPush,                                           // Append at the end
    opPop,                                            // Remove from the end
    opAdd,                                            // Add, new value back
    opAddAfter,                                       // Add, old value back
    opSub,                                            // Subtract, new value back
    opSubAfter,                                       // Subtract, old value back
    opOr,
    opXor,
    opAnd,
    opNot                                             // Bitwise not
  } heapOp;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                                  // Unallocated or freed array
    errOutOfBounds,                                   // Index at or past the size
    errFull,                                          // Push to a full array
    errEmpty,                                         // Pop from an empty array
    errOutOfMemory                                    // Every array in use
  } heapError;

  typedef enum logic [1:0] {
    stIdle,
    stLookup,
    stExecute,
    stRespond
  } controlState;

  // ------------------------------
  // Records
  // ------------------------------
  typedef struct packed {
    logic [arrayBits-1:0] array;
    logic [indexBits-1:0] index;
  } elementAddress;

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;                          // Informational only
    elementAddress       adr;
    logic [dataBits-1:0] dat;
    heapOp               tgc;                         // Opcode rides on the cycle tag
  } wbRequest;

  typedef struct packed {
    logic                ack;
    logic                err;
    logic [dataBits-1:0] dat;
  } wbResponse;

  typedef struct packed {
    logic                 allocate;                   // Hand out the next array
    logic                 deallocate;                 // Return array to the free stack
    logic                 sizeWrite;                  // Load newSize
    logic [arrayBits-1:0] array;
    logic [sizeBits-1:0]  newSize;
  } directoryCommand;

  typedef struct packed {
    logic                 allocated;                  // Addressed array in use
    logic [sizeBits-1:0]  size;                       // Addressed array size
    logic                 canAllocate;
    logic [arrayBits-1:0] allocatedArray;             // Number the next allocation gives
  } directoryStatus;

endpackage
